// File: list.f
source/ctl_pkg.sv
source/ctl_ram.sv
source/cpu_bus_port.sv
source/cycle_table.sv
source/ctl_sequencer.sv
source/ctl_top.sv
tb/ctl_top_tb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ctl_top_tb -f list.f \
        -o ctl_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ctl_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"

// File: tb/ctl_top_tb.sv
`timescale 1ns/100ps
module ctl_top_tb;
        import ctl_pkg::*;

        localparam int NUM_ROWS = 6;
        localparam int NUM_PRM = 10;
        localparam int UPDATE_WAIT = 24; // two polling loops.
        localparam int HS_CYCLES = 10; // worst case per host handshake.
        localparam int ACK_LIMIT = 8;
        localparam int SYNC_LIMIT = CYCLE_DEPTH + 12 + 2 * 12 + 8;
        localparam int MAX_CYCLES = NUM_ROWS * (UPDATE_WAIT + (NUM_PRM + 2) * HS_CYCLES)
                + (CYCLE_DEPTH + 8) * HS_CYCLES + SYNC_LIMIT + UPDATE_WAIT
                + CYCLE_DEPTH * 2 + 12 * (HS_CYCLES + 2) + 500;

        logic CLK, rst_n, bus_req, bus_we, bus_ack, thermo, sync_set;
        logic [ADDR_W-1:0] bus_addr;
        logic [DATA_W-1:0] bus_wdata, bus_rdata;
        logic [CYCLE_IDX_W-1:0] cycle_idx;
        logic [CYCLE_WIDTH-1:0] cycle_val, step_s;
        logic legacy_mode, force_fan, op_mode, stm_gain_mode;
        logic [15:0] cycle_m, cycle_s, cycle_stm, ecat_sync_cycle_ticks;
        logic [31:0] freq_div_m, freq_div_stm, sound_speed;
        logic [63:0] ecat_sync_time;

        int seed;
        int cycle_cnt = 0;
        int sync_cnt = 0;

        // stimulus and expected rows.
        logic [ADDR_W-1:0] prm_addr [NUM_PRM];
        logic [DATA_W-1:0] prm_val [NUM_ROWS][NUM_PRM];
        logic [3:0] flag_val [NUM_ROWS]; // {stm_gain, op, fan, legacy}.
        logic thermo_val [NUM_ROWS];
        logic [31:0] exp_fdm [NUM_ROWS];
        logic [31:0] exp_fds [NUM_ROWS];
        logic [31:0] exp_snd [NUM_ROWS];
        logic [CYCLE_WIDTH-1:0] exp_step [NUM_ROWS];
        logic [DATA_W-1:0] cyc_word [CYCLE_DEPTH];
        logic [DATA_W-1:0] sync_word [5]; // ticks, then time words lsw first.

        ctl_top dut (.*);

        always #50 CLK = ~CLK;

        always @(posedge CLK) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt == MAX_CYCLES) give_up("timeout, the run went past its cycle limit");
        end

        always @(posedge CLK) begin
                if (sync_set === 1'b1) sync_cnt <= sync_cnt + 1;
        end

        task automatic give_up(input string why);
                $display("%s", why);
                $display("=== FAIL ===");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
                if (actual !== expected) begin
                        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
                        $display("=== FAIL ===");
                        $fatal(1, "value mismatch");
                end
        endtask

        task automatic wait_ack(input logic level);
                int n;
                n = 0;
                @(posedge CLK);
                while (bus_ack !== level && n < ACK_LIMIT) begin
                        @(posedge CLK);
                        n++;
                end
                if (bus_ack !== level && level) give_up("bus_ack never rose after bus_req");
                if (bus_ack !== level) give_up("bus_ack stayed high after bus_req dropped");
        endtask

        task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
                @(posedge CLK);
                bus_we <= 1'b1;
                bus_addr <= addr;
                bus_wdata <= data;
                @(posedge CLK);
                bus_req <= 1'b1;
                wait_ack(1'b1);
                bus_req <= 1'b0;
                wait_ack(1'b0);
        endtask

        task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
                @(posedge CLK);
                bus_we <= 1'b0;
                bus_addr <= addr;
                @(posedge CLK);
                bus_req <= 1'b1;
                wait_ack(1'b1);
                data = bus_rdata; // registered together with ack.
                bus_req <= 1'b0;
                wait_ack(1'b0);
        endtask

        function automatic logic [DATA_W-1:0] make_ctl(input logic [3:0] flags, input logic sync);
                logic [DATA_W-1:0] w;
                w = '0;
                w[CTL_LEGACY_MODE_BIT] = flags[0];
                w[CTL_FORCE_FAN_BIT] = flags[1];
                w[CTL_OP_MODE_BIT] = flags[2];
                w[CTL_STM_GAIN_MODE_BIT] = flags[3];
                w[CTL_SYNC_BIT] = sync;
                return w;
        endfunction

        initial begin
                logic [DATA_W-1:0] rd;
                logic [3:0] sync_flags;
                int n;
                seed = 32'h363326c2;
                CLK = 1'b0;
                rst_n = 1'b0;
                bus_req = 1'b0;
                bus_we = 1'b0;
                bus_addr = '0;
                bus_wdata = '0;
                thermo = 1'b0;
                cycle_idx = '0;
                prm_addr = '{ADDR_MOD_CYCLE, ADDR_MOD_FREQ_DIV_0, ADDR_MOD_FREQ_DIV_1,
                        ADDR_SILENT_CYCLE, ADDR_SILENT_STEP, ADDR_STM_CYCLE, ADDR_STM_FREQ_DIV_0,
                        ADDR_STM_FREQ_DIV_1, ADDR_SOUND_SPEED_0, ADDR_SOUND_SPEED_1};
                for (int r = 0; r < NUM_ROWS; r++) begin
                        for (int p = 0; p < NUM_PRM; p++) prm_val[r][p] = DATA_W'($random(seed));
                        flag_val[r] = 4'($random(seed));
                        thermo_val[r] = (r % 2 == 0); // toggles every row.
                        exp_fdm[r] = {prm_val[r][2], prm_val[r][1]};
                        exp_fds[r] = {prm_val[r][7], prm_val[r][6]};
                        exp_snd[r] = {prm_val[r][9], prm_val[r][8]};
                        exp_step[r] = prm_val[r][4][CYCLE_WIDTH-1:0];
                end
                for (int i = 0; i < CYCLE_DEPTH; i++) cyc_word[i] = DATA_W'($random(seed));
                for (int k = 0; k < 5; k++) sync_word[k] = DATA_W'($random(seed));
                sync_flags = 4'($random(seed));

                repeat (4) @(posedge CLK);
                check("reset flags", '0, {bus_ack, sync_set, stm_gain_mode, op_mode, force_fan,
                        legacy_mode});
                check("reset params", '0, |{cycle_m, freq_div_m, cycle_s, step_s, cycle_stm,
                        freq_div_stm, sound_speed, ecat_sync_time, ecat_sync_cycle_ticks});
                @(posedge CLK);
                rst_n <= 1'b1;
                repeat (8) @(posedge CLK); // version write and start of polling.

                read_word(ADDR_VERSION_NUM, rd);
                check("version word", {ENABLED_FEATURES, VERSION_NUM}, rd);

                for (int r = 0; r < NUM_ROWS; r++) begin
                        for (int p = 0; p < NUM_PRM; p++) write_word(prm_addr[p], prm_val[r][p]);
                        write_word(ADDR_CTL_REG, make_ctl(flag_val[r], 1'b0));
                        thermo <= thermo_val[r];
                        repeat (UPDATE_WAIT) @(posedge CLK);
                        check("cycle_m", prm_val[r][0], cycle_m);
                        check("freq_div_m", exp_fdm[r], freq_div_m);
                        check("cycle_s", prm_val[r][3], cycle_s);
                        check("step_s", exp_step[r], step_s);
                        check("cycle_stm", prm_val[r][5], cycle_stm);
                        check("freq_div_stm", exp_fds[r], freq_div_stm);
                        check("sound_speed", exp_snd[r], sound_speed);
                        check("flags", flag_val[r],
                                {stm_gain_mode, op_mode, force_fan, legacy_mode});
                        read_word(ADDR_FPGA_INFO, rd);
                        check("info thermo", thermo_val[r], rd[0]);
                end

                write_word(ADDR_EC_SYNC_CYCLE_TICKS, sync_word[0]);
                for (int k = 0; k < 4; k++) begin
                        write_word(ADDR_W'(ADDR_EC_SYNC_TIME_0 + k), sync_word[k+1]);
                end
                for (int i = 0; i < CYCLE_DEPTH; i++) begin
                        write_word(ADDR_W'(ADDR_CYCLE_BASE + i), cyc_word[i]);
                end
                check("sync pulses before sync", 0, sync_cnt);
                write_word(ADDR_CTL_REG, make_ctl(sync_flags, 1'b1));
                n = 0;
                while (sync_set !== 1'b1 && n < SYNC_LIMIT) begin
                        @(posedge CLK);
                        n++;
                end
                if (sync_set !== 1'b1) give_up("no sync_set pulse after the sync bit was set");
                repeat (UPDATE_WAIT) @(posedge CLK);
                check("sync pulses", 1, sync_cnt);
                check("ecat_sync_cycle_ticks", sync_word[0], ecat_sync_cycle_ticks);
                check("ecat_sync_time", {sync_word[4], sync_word[3], sync_word[2], sync_word[1]},
                        ecat_sync_time);
                check("flags after sync", sync_flags,
                        {stm_gain_mode, op_mode, force_fan, legacy_mode});
                read_word(ADDR_CTL_REG, rd);
                check("ctl after sync", make_ctl(sync_flags, 1'b0), rd);
                for (int i = 0; i < CYCLE_DEPTH; i++) begin
                        cycle_idx <= CYCLE_IDX_W'(i);
                        repeat (2) @(posedge CLK); // idx sampled, then value registered.
                        check("cycle_val", cyc_word[i][CYCLE_WIDTH-1:0], cycle_val);
                end

                thermo <= 1'b1;
                repeat (UPDATE_WAIT) @(posedge CLK);

                // reads land on every phase of the info write-back.
                for (int k = 0; k < 12; k++) begin
                        repeat (3) @(posedge CLK);
                        read_word(ADDR_FPGA_INFO, rd);
                        check("info during polling", thermo, rd[0]);
                end

                $display("=== PASS ===");
                $finish;
        end

endmodule

// File: source/ctl_top.sv
`timescale 1ns/100ps
module ctl_top (
        input  logic CLK,
        input  logic rst_n,
        input  logic bus_req,
        input  logic bus_we,
        input  logic [ctl_pkg::ADDR_W-1:0] bus_addr,
        input  logic [ctl_pkg::DATA_W-1:0] bus_wdata,
        output logic [ctl_pkg::DATA_W-1:0] bus_rdata,
        output logic bus_ack,
        input  logic thermo,
        input  logic [ctl_pkg::CYCLE_IDX_W-1:0] cycle_idx,
        output logic [ctl_pkg::CYCLE_WIDTH-1:0] cycle_val,
        output logic legacy_mode,
        output logic force_fan,
        output logic op_mode,
        output logic stm_gain_mode,
        output logic [15:0] cycle_m,
        output logic [31:0] freq_div_m,
        output logic [15:0] cycle_s,
        output logic [ctl_pkg::CYCLE_WIDTH-1:0] step_s,
        output logic [15:0] cycle_stm,
        output logic [31:0] freq_div_stm,
        output logic [31:0] sound_speed,
        output logic [63:0] ecat_sync_time,
        output logic [15:0] ecat_sync_cycle_ticks,
        output logic sync_set
);
        import ctl_pkg::*;

        logic a_en;
        logic a_we;
        logic [ADDR_W-1:0] a_addr;
        logic [DATA_W-1:0] a_wdata;
        logic [DATA_W-1:0] a_rdata;
        logic b_we;
        logic [ADDR_W-1:0] b_addr;
        logic [DATA_W-1:0] b_wdata;
        logic [DATA_W-1:0] b_rdata;
        logic tbl_clear;
        logic tbl_wr;
        logic [DATA_W-1:0] tbl_data;

        cpu_bus_port u_port (
                .CLK, .rst_n, .bus_req, .bus_we, .bus_addr, .bus_wdata, .bus_rdata, .bus_ack,
                .ram_en(a_en), .ram_we(a_we), .ram_addr(a_addr), .ram_wdata(a_wdata),
                .ram_rdata(a_rdata)
        );

        ctl_ram u_ram (
                .CLK, .a_en, .a_we, .a_addr, .a_wdata, .a_rdata,
                .b_we, .b_addr, .b_wdata, .b_rdata
        );

        // host side on port a, sequencer on port b.
        ctl_sequencer u_seq (
                .CLK, .rst_n, .thermo,
                .ram_we(b_we), .ram_addr(b_addr), .ram_wdata(b_wdata), .ram_rdata(b_rdata),
                .legacy_mode, .force_fan, .op_mode, .stm_gain_mode,
                .cycle_m, .freq_div_m, .cycle_s, .step_s, .cycle_stm, .freq_div_stm,
                .sound_speed, .ecat_sync_time, .ecat_sync_cycle_ticks, .sync_set,
                .tbl_clear, .tbl_wr, .tbl_data
        );

        cycle_table u_table (
                .CLK, .rst_n, .tbl_clear, .tbl_wr, .tbl_data, .cycle_idx, .cycle_val
        );

endmodule

// File: source/ctl_sequencer.sv
`timescale 1ns/100ps
module ctl_sequencer (
        input  logic CLK,
        input  logic rst_n,
        input  logic thermo,
        output logic ram_we,
        output logic [ctl_pkg::ADDR_W-1:0] ram_addr,
        output logic [ctl_pkg::DATA_W-1:0] ram_wdata,
        input  logic [ctl_pkg::DATA_W-1:0] ram_rdata,
        output logic legacy_mode,
        output logic force_fan,
        output logic op_mode,
        output logic stm_gain_mode,
        output logic [15:0] cycle_m,
        output logic [31:0] freq_div_m,
        output logic [15:0] cycle_s,
        output logic [ctl_pkg::CYCLE_WIDTH-1:0] step_s,
        output logic [15:0] cycle_stm,
        output logic [31:0] freq_div_stm,
        output logic [31:0] sound_speed,
        output logic [63:0] ecat_sync_time,
        output logic [15:0] ecat_sync_cycle_ticks,
        output logic sync_set,
        output logic tbl_clear,
        output logic tbl_wr,
        output logic [ctl_pkg::DATA_W-1:0] tbl_data
);
        import ctl_pkg::*;

        // each state captures the word requested three states back.
        typedef enum logic [4:0] {
                S_WR_VER, S_REQ_CTL, S_WAIT_0, S_WAIT_1,
                S_CTL, S_REQ_MFD1, S_MC, S_MFD0, S_MFD1, S_SC, S_SS,
                S_STMC, S_STMFD0, S_STMFD1, S_SSP0, S_SSP1,
                S_REQ_TICKS, S_REQ_T0, S_REQ_T1, S_RD_TICKS, S_RD_T0,
                S_RD_T1, S_RD_T2, S_RD_T3, S_RD_CYCLE,
                S_WAIT_CLR_0, S_WAIT_CLR_1, S_CLR_SYNC
        } state_t;

        state_t state;
        ctl_word_u ctl;
        ctl_word_u rd_ctl;
        logic [DATA_W-1:0] clr_raw;
        logic [CYCLE_IDX_W-1:0] set_cnt;

        assign rd_ctl.raw = ram_rdata;
        assign clr_raw = rd_ctl.raw & ~(DATA_W'(1) << CTL_SYNC_BIT);

        assign legacy_mode = ctl.f.legacy_mode;
        assign force_fan = ctl.f.force_fan;
        assign op_mode = ctl.f.op_mode;
        assign stm_gain_mode = ctl.f.stm_gain_mode;

        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        state <= S_WR_VER;
                        ram_we <= 1'b0;
                        ram_addr <= '0;
                        ram_wdata <= '0;
                        ctl <= '0;
                        cycle_m <= '0;
                        freq_div_m <= '0;
                        cycle_s <= '0;
                        step_s <= '0;
                        cycle_stm <= '0;
                        freq_div_stm <= '0;
                        sound_speed <= '0;
                        ecat_sync_time <= '0;
                        ecat_sync_cycle_ticks <= '0;
                        sync_set <= 1'b0;
                        set_cnt <= '0;
                        tbl_clear <= 1'b0;
                        tbl_wr <= 1'b0;
                        tbl_data <= '0;
                end else begin
                        tbl_clear <= 1'b0;
                        tbl_wr <= 1'b0;
                        case (state)
                        S_WR_VER: begin
                                ram_we <= 1'b1;
                                ram_addr <= ADDR_VERSION_NUM;
                                ram_wdata <= {ENABLED_FEATURES, VERSION_NUM};
                                state <= S_REQ_CTL;
                        end
                        S_REQ_CTL: begin
                                ram_we <= 1'b0;
                                ram_addr <= ADDR_CTL_REG;
                                state <= S_WAIT_0;
                        end
                        S_WAIT_0: state <= S_WAIT_1;
                        S_WAIT_1: begin
                                ram_addr <= ADDR_MOD_CYCLE; // primes the first loop.
                                state <= S_CTL;
                        end
                        S_CTL: begin
                                ctl <= rd_ctl;
                                if (rd_ctl.f.sync) begin
                                        state <= S_REQ_TICKS;
                                end else begin
                                        ram_addr <= ADDR_MOD_FREQ_DIV_0;
                                        state <= S_REQ_MFD1;
                                end
                        end
                        S_REQ_MFD1: begin
                                ram_addr <= ADDR_MOD_FREQ_DIV_1;
                                state <= S_MC;
                        end
                        S_MC: begin
                                cycle_m <= ram_rdata;
                                ram_addr <= ADDR_SILENT_CYCLE;
                                state <= S_MFD0;
                        end
                        S_MFD0: begin
                                freq_div_m[15:0] <= ram_rdata;
                                ram_addr <= ADDR_SILENT_STEP;
                                state <= S_MFD1;
                        end
                        S_MFD1: begin
                                freq_div_m[31:16] <= ram_rdata;
                                ram_addr <= ADDR_STM_CYCLE;
                                state <= S_SC;
                        end
                        S_SC: begin
                                cycle_s <= ram_rdata;
                                ram_addr <= ADDR_STM_FREQ_DIV_0;
                                state <= S_SS;
                        end
                        S_SS: begin
                                step_s <= ram_rdata[CYCLE_WIDTH-1:0];
                                ram_addr <= ADDR_STM_FREQ_DIV_1;
                                state <= S_STMC;
                        end
                        S_STMC: begin
                                cycle_stm <= ram_rdata;
                                ram_addr <= ADDR_SOUND_SPEED_0;
                                state <= S_STMFD0;
                        end
                        S_STMFD0: begin
                                freq_div_stm[15:0] <= ram_rdata;
                                ram_addr <= ADDR_SOUND_SPEED_1;
                                state <= S_STMFD1;
                        end
                        S_STMFD1: begin
                                freq_div_stm[31:16] <= ram_rdata;
                                ram_addr <= ADDR_CTL_REG;
                                state <= S_SSP0;
                        end
                        S_SSP0: begin
                                sound_speed[15:0] <= ram_rdata;
                                ram_we <= 1'b1; // thermal state out.
                                ram_addr <= ADDR_FPGA_INFO;
                                ram_wdata <= {{(DATA_W-1){1'b0}}, thermo};
                                state <= S_SSP1;
                        end
                        S_SSP1: begin
                                sound_speed[31:16] <= ram_rdata;
                                ram_we <= 1'b0;
                                ram_addr <= ADDR_MOD_CYCLE;
                                state <= S_CTL;
                        end
                        S_REQ_TICKS: begin
                                ram_addr <= ADDR_EC_SYNC_CYCLE_TICKS;
                                state <= S_REQ_T0;
                        end
                        S_REQ_T0: begin
                                ram_addr <= ADDR_EC_SYNC_TIME_0;
                                state <= S_REQ_T1;
                        end
                        S_REQ_T1: begin
                                ram_addr <= ADDR_EC_SYNC_TIME_1;
                                state <= S_RD_TICKS;
                        end
                        S_RD_TICKS: begin
                                ecat_sync_cycle_ticks <= ram_rdata;
                                ram_addr <= ADDR_EC_SYNC_TIME_2;
                                state <= S_RD_T0;
                        end
                        S_RD_T0: begin
                                ecat_sync_time[15:0] <= ram_rdata;
                                ram_addr <= ADDR_EC_SYNC_TIME_3;
                                state <= S_RD_T1;
                        end
                        S_RD_T1: begin
                                ecat_sync_time[31:16] <= ram_rdata;
                                ram_addr <= ADDR_CYCLE_BASE;
                                state <= S_RD_T2;
                        end
                        S_RD_T2: begin
                                ecat_sync_time[47:32] <= ram_rdata;
                                ram_addr <= ram_addr + 1'b1;
                                state <= S_RD_T3;
                        end
                        S_RD_T3: begin
                                ecat_sync_time[63:48] <= ram_rdata;
                                ram_addr <= ram_addr + 1'b1;
                                set_cnt <= '0;
                                tbl_clear <= 1'b1; // rewind the table.
                                state <= S_RD_CYCLE;
                        end
                        S_RD_CYCLE: begin
                                tbl_wr <= 1'b1;
                                tbl_data <= ram_rdata;
                                if (set_cnt == CYCLE_IDX_W'(CYCLE_DEPTH - 1)) begin
                                        ram_addr <= ADDR_CTL_REG;
                                        sync_set <= 1'b1;
                                        state <= S_WAIT_CLR_0;
                                end else begin
                                        ram_addr <= ram_addr + 1'b1;
                                        set_cnt <= set_cnt + 1'b1;
                                end
                        end
                        S_WAIT_CLR_0: begin
                                sync_set <= 1'b0;
                                state <= S_WAIT_CLR_1;
                        end
                        S_WAIT_CLR_1: state <= S_CLR_SYNC;
                        default: begin
                                // fresh control word, written back without sync.
                                ctl <= rd_ctl;
                                ram_we <= 1'b1;
                                ram_wdata <= clr_raw;
                                state <= S_REQ_CTL;
                        end
                        endcase
                end
        end

        sync_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n)
                sync_set |=> !sync_set);
        tbl_wr_in_sync: assert property (@(posedge CLK) disable iff (!rst_n)
                tbl_wr |-> state inside {S_RD_CYCLE, S_WAIT_CLR_0});

endmodule

// File: source/cycle_table.sv
`timescale 1ns/100ps
module cycle_table (
        input  logic CLK,
        input  logic rst_n,
        input  logic tbl_clear,
        input  logic tbl_wr,
        input  logic [ctl_pkg::DATA_W-1:0] tbl_data,
        input  logic [ctl_pkg::CYCLE_IDX_W-1:0] cycle_idx,
        output logic [ctl_pkg::CYCLE_WIDTH-1:0] cycle_val
);
        import ctl_pkg::*;

        logic [CYCLE_WIDTH-1:0] cycle [0:CYCLE_DEPTH-1];
        logic [CYCLE_IDX_W-1:0] wr_ptr;

        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                end else if (tbl_clear) begin
                        wr_ptr <= '0;
                end else if (tbl_wr) begin
                        wr_ptr <= wr_ptr + 1'b1;
                end
        end

        always_ff @(posedge CLK) begin
                if (tbl_wr) cycle[wr_ptr] <= tbl_data[CYCLE_WIDTH-1:0];
                cycle_val <= cycle[cycle_idx]; // one-cycle read.
        end

        no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
                tbl_wr |-> wr_ptr != CYCLE_IDX_W'(CYCLE_DEPTH));

endmodule

// File: source/cpu_bus_port.sv
`timescale 1ns/100ps
module cpu_bus_port (
        input  logic CLK,
        input  logic rst_n,
        input  logic bus_req,
        input  logic bus_we,
        input  logic [ctl_pkg::ADDR_W-1:0] bus_addr,
        input  logic [ctl_pkg::DATA_W-1:0] bus_wdata,
        output logic [ctl_pkg::DATA_W-1:0] bus_rdata,
        output logic bus_ack,
        output logic ram_en,
        output logic ram_we,
        output logic [ctl_pkg::ADDR_W-1:0] ram_addr,
        output logic [ctl_pkg::DATA_W-1:0] ram_wdata,
        input  logic [ctl_pkg::DATA_W-1:0] ram_rdata
);
        import ctl_pkg::*;

        typedef enum logic [1:0] {ST_IDLE, ST_WAIT_RD, ST_ACK, ST_RELEASE} state_t;

        state_t state;
        logic [1:0] lat_cnt;

        // one access per handshake, fired as the request is seen.
        assign ram_en = (state == ST_IDLE) && bus_req;
        assign ram_we = ram_en && bus_we;
        assign ram_addr = bus_addr;
        assign ram_wdata = bus_wdata;

        always_ff @(posedge CLK or negedge rst_n) begin
                if (!rst_n) begin
                        state <= ST_IDLE;
                        bus_ack <= 1'b0;
                        lat_cnt <= '0;
                end else begin
                        case (state)
                        ST_IDLE: begin
                                if (bus_req && bus_we) begin
                                        bus_ack <= 1'b1; // writes ack at once.
                                        state <= ST_RELEASE;
                                end else if (bus_req) begin
                                        lat_cnt <= 2'(RAM_RD_LAT - 1);
                                        state <= ST_WAIT_RD;
                                end
                        end
                        ST_WAIT_RD: begin
                                lat_cnt <= lat_cnt - 1'b1;
                                if (lat_cnt == 2'd1) state <= ST_ACK; // last wait cycle.
                        end
                        ST_ACK: begin
                                bus_ack <= 1'b1;
                                state <= ST_RELEASE;
                        end
                        default: begin
                                if (!bus_req) begin
                                        bus_ack <= 1'b0;
                                        state <= ST_IDLE;
                                end
                        end
                        endcase
                end
        end

        always_ff @(posedge CLK) begin
                if (state == ST_ACK) bus_rdata <= ram_rdata;
        end

        ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
                $rose(bus_ack) |-> bus_req);

endmodule

// File: source/ctl_ram.sv
`timescale 1ns/100ps
module ctl_ram (
        input  logic CLK,
        input  logic a_en,
        input  logic a_we,
        input  logic [ctl_pkg::ADDR_W-1:0] a_addr,
        input  logic [ctl_pkg::DATA_W-1:0] a_wdata,
        output logic [ctl_pkg::DATA_W-1:0] a_rdata,
        input  logic b_we,
        input  logic [ctl_pkg::ADDR_W-1:0] b_addr,
        input  logic [ctl_pkg::DATA_W-1:0] b_wdata,
        output logic [ctl_pkg::DATA_W-1:0] b_rdata
);
        import ctl_pkg::*;

        logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

        logic a_en_q;
        logic a_we_q;
        logic [ADDR_W-1:0] a_addr_q;
        logic [DATA_W-1:0] a_wdata_q;
        logic b_we_q;
        logic [ADDR_W-1:0] b_addr_q;
        logic [DATA_W-1:0] b_wdata_q;

        always_ff @(posedge CLK) begin
                a_en_q <= a_en; // address stage.
                a_we_q <= a_en & a_we;
                a_addr_q <= a_addr;
                a_wdata_q <= a_wdata;
                b_we_q <= b_we;
                b_addr_q <= b_addr;
                b_wdata_q <= b_wdata;
        end

        // port b written last, so it wins a collision.
        always_ff @(posedge CLK) begin
                if (a_en_q) a_rdata <= mem[a_addr_q];
                b_rdata <= mem[b_addr_q];
                if (a_we_q) mem[a_addr_q] <= a_wdata_q;
                if (b_we_q) mem[b_addr_q] <= b_wdata_q;
        end

        a_addr_known: assert property (@(posedge CLK) a_we_q |-> !$isunknown(a_addr_q));
        b_addr_known: assert property (@(posedge CLK) b_we_q |-> !$isunknown(b_addr_q));

endmodule

// File: source/ctl_pkg.sv
package ctl_pkg;

        localparam int ADDR_W = 9;
        localparam int DATA_W = 16;
        localparam int RAM_RD_LAT = 2; // both ports.

        localparam int CYCLE_WIDTH = 13;
        localparam int CYCLE_DEPTH = 249;
        localparam int CYCLE_IDX_W = 8;

        localparam logic [7:0] VERSION_NUM = 8'h83;
        localparam logic [7:0] ENABLED_FEATURES = 8'h01;

        localparam logic [ADDR_W-1:0] ADDR_CTL_REG = 9'h000;
        localparam logic [ADDR_W-1:0] ADDR_FPGA_INFO = 9'h001;
        localparam logic [ADDR_W-1:0] ADDR_EC_SYNC_CYCLE_TICKS = 9'h010;
        localparam logic [ADDR_W-1:0] ADDR_EC_SYNC_TIME_0 = 9'h011;
        localparam logic [ADDR_W-1:0] ADDR_EC_SYNC_TIME_1 = 9'h012;
        localparam logic [ADDR_W-1:0] ADDR_EC_SYNC_TIME_2 = 9'h013;
        localparam logic [ADDR_W-1:0] ADDR_EC_SYNC_TIME_3 = 9'h014;
        localparam logic [ADDR_W-1:0] ADDR_MOD_CYCLE = 9'h020;
        localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_0 = 9'h021;
        localparam logic [ADDR_W-1:0] ADDR_MOD_FREQ_DIV_1 = 9'h022;
        localparam logic [ADDR_W-1:0] ADDR_VERSION_NUM = 9'h03f;
        localparam logic [ADDR_W-1:0] ADDR_SILENT_CYCLE = 9'h040;
        localparam logic [ADDR_W-1:0] ADDR_SILENT_STEP = 9'h041;
        localparam logic [ADDR_W-1:0] ADDR_STM_CYCLE = 9'h050;
        localparam logic [ADDR_W-1:0] ADDR_STM_FREQ_DIV_0 = 9'h051;
        localparam logic [ADDR_W-1:0] ADDR_STM_FREQ_DIV_1 = 9'h052;
        localparam logic [ADDR_W-1:0] ADDR_SOUND_SPEED_0 = 9'h053;
        localparam logic [ADDR_W-1:0] ADDR_SOUND_SPEED_1 = 9'h054;
        localparam logic [ADDR_W-1:0] ADDR_CYCLE_BASE = 9'h100; // CYCLE_DEPTH words.

        localparam int CTL_LEGACY_MODE_BIT = 0;
        localparam int CTL_FORCE_FAN_BIT = 4;
        localparam int CTL_OP_MODE_BIT = 5;
        localparam int CTL_STM_GAIN_MODE_BIT = 6;
        localparam int CTL_SYNC_BIT = 8;

        // field order follows the bit positions above.
        typedef struct packed {
                logic [DATA_W-CTL_SYNC_BIT-2:0] rsv_hi;
                logic sync;
                logic [CTL_SYNC_BIT-CTL_STM_GAIN_MODE_BIT-2:0] rsv_mid;
                logic stm_gain_mode;
                logic op_mode;
                logic force_fan;
                logic [CTL_FORCE_FAN_BIT-CTL_LEGACY_MODE_BIT-2:0] rsv_lo;
                logic legacy_mode;
        } ctl_flags_t;

        typedef union packed {
                logic [DATA_W-1:0] raw;
                ctl_flags_t f;
        } ctl_word_u;

endpackage
